// File: flist.f
+incdir+tb
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_stage.sv
tb/tb_id_stage.sv

// File: hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  decode_pkg::br_kind_t        br_kind,
    input  logic                 [31:0] pc,
    input  logic                 [15:0] imm,
    input  logic                 [25:0] jidx,
    input  logic                 [31:0] rs_value,
    input  logic                 [31:0] rt_value,
    output logic                        is_branch,
    output logic                        taken,
    output logic                 [31:0] target
);
    import decode_pkg::*;

    logic [31:0] slot_pc;   // delay-slot pc
    logic [31:0] br_offset;
    logic        rs_eq_rt;

    assign slot_pc   = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign is_branch = (br_kind != br_none);

    always_comb begin
        taken  = 1'b0;
        target = slot_pc + br_offset;
        case (br_kind)
            br_beq: taken = rs_eq_rt;
            br_bne: taken = !rs_eq_rt;
            br_j, br_jal: begin
                taken  = 1'b1;
                target = {slot_pc[31:28], jidx, 2'b00}; // stays in the 256MB region
            end
            br_jr: begin
                taken  = 1'b1;
                target = rs_value;
            end
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/decode_pkg.sv
package decode_pkg;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [4:0] reg_ra = 5'd31; // link register

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } j_fmt_t;

    // same 32-bit word seen as R, I or J format
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        j_fmt_t j_view;
    } inst_word_t;

    // one-hot, add sits in bit 0
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    typedef enum logic [1:0] {
        src2_reg  = 2'b00,
        src2_zext = 2'b01,
        src2_sext = 2'b10
    } src2_sel_t;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_j, br_jal, br_jr
    } br_kind_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_word_t  inst;
    } fetch_bus_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        load_op;
        logic        mem_we;
        logic        gr_we;
        logic        src1_is_sa;
        logic        src1_is_pc;
        src2_sel_t   src2_sel;
        logic        src2_is_8; // link address is pc + 8
        logic [4:0]  dest;
        logic [15:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;   // 0 when the stage writes nothing
        logic [31:0] result;
    } fwd_src_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        is_branch;
        logic        stall;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

endpackage

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_to_ds_valid,
    input  decode_pkg::fetch_bus_t fs_to_ds_bus,
    output logic                   ds_allowin,
    input  logic                   es_allowin,
    output logic                   ds_to_es_valid,
    output decode_pkg::ds_to_es_t  ds_to_es_bus,
    output decode_pkg::br_bus_t    br_bus,
    input  decode_pkg::rf_write_t  ws_to_rf,
    input  decode_pkg::fwd_src_t   exe_fwd,
    input  decode_pkg::fwd_src_t   mem_fwd,
    input  decode_pkg::fwd_src_t   wb_fwd,
    input  logic                   es_load_op
);
    import decode_pkg::*;

    logic        ds_valid;
    fetch_bus_t  fs_to_ds_bus_r; // held instruction and pc
    logic        ds_ready_go;
    ctrl_t       ctrl;
    br_kind_t    br_kind;
    logic        rs_used;
    logic        rt_used;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        load_stall;
    logic        is_branch;
    logic        br_taken;
    logic [31:0] br_target;

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_bus_r <= fs_to_ds_bus;
        end
    end

    inst_decoder u_decoder (
        .inst    (fs_to_ds_bus_r.inst),
        .ctrl    (ctrl),
        .br_kind (br_kind),
        .rs_used (rs_used),
        .rt_used (rt_used)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (fs_to_ds_bus_r.inst.r_view.rs),
        .raddr2 (fs_to_ds_bus_r.inst.r_view.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_to_rf)
    );

    operand_forward u_forward (
        .rs         (fs_to_ds_bus_r.inst.r_view.rs),
        .rt         (fs_to_ds_bus_r.inst.r_view.rt),
        .rs_used    (rs_used),
        .rt_used    (rt_used),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .br_kind   (br_kind),
        .pc        (fs_to_ds_bus_r.pc),
        .imm       (fs_to_ds_bus_r.inst.i_view.imm),
        .jidx      (fs_to_ds_bus_r.inst.j_view.jidx),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .is_branch (is_branch),
        .taken     (br_taken),
        .target    (br_target)
    );

    assign ds_to_es_bus = '{ctrl: ctrl, rs_value: rs_value, rt_value: rt_value,
                            pc: fs_to_ds_bus_r.pc};

    // only a live instruction may redirect fetch
    assign br_bus.is_branch = ds_valid & is_branch;
    assign br_bus.taken     = ds_valid & br_taken;
    assign br_bus.stall     = load_stall & br_bus.taken; // target not final yet
    assign br_bus.target    = br_target;

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::inst_word_t inst,
    output decode_pkg::ctrl_t      ctrl,
    output decode_pkg::br_kind_t   br_kind,
    output logic                   rs_used,
    output logic                   rt_used
);
    import decode_pkg::*;

    logic [5:0] op;
    logic [5:0] func;
    logic       special;
    logic       no_sa;      // sa field must be zero
    logic       i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic       i_sll, i_srl, i_sra, i_jr;
    logic       i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic       i_lw, i_sw, i_beq, i_bne, i_j, i_jal;
    logic       r_alu;      // register-register ops writing rd
    logic       imm_arith;  // writes rt from an immediate
    logic       defined;

    assign op      = inst.r_view.op;
    assign func    = inst.r_view.func;
    assign special = (op == op_special);
    assign no_sa   = (inst.r_view.sa == 5'd0);

    assign i_addu  = special && func == fn_addu && no_sa;
    assign i_subu  = special && func == fn_subu && no_sa;
    assign i_slt   = special && func == fn_slt  && no_sa;
    assign i_sltu  = special && func == fn_sltu && no_sa;
    assign i_and   = special && func == fn_and  && no_sa;
    assign i_or    = special && func == fn_or   && no_sa;
    assign i_xor   = special && func == fn_xor  && no_sa;
    assign i_nor   = special && func == fn_nor  && no_sa;
    assign i_sll   = special && func == fn_sll  && inst.r_view.rs == 5'd0;
    assign i_srl   = special && func == fn_srl  && inst.r_view.rs == 5'd0;
    assign i_sra   = special && func == fn_sra  && inst.r_view.rs == 5'd0;
    assign i_jr    = special && func == fn_jr   && no_sa
                     && inst.r_view.rt == 5'd0 && inst.r_view.rd == 5'd0;
    assign i_addiu = (op == op_addiu);
    assign i_slti  = (op == op_slti);
    assign i_sltiu = (op == op_sltiu);
    assign i_andi  = (op == op_andi);
    assign i_ori   = (op == op_ori);
    assign i_xori  = (op == op_xori);
    assign i_lui   = (op == op_lui) && inst.i_view.rs == 5'd0;
    assign i_lw    = (op == op_lw);
    assign i_sw    = (op == op_sw);
    assign i_beq   = (op == op_beq);
    assign i_bne   = (op == op_bne);
    assign i_j     = (op == op_j);
    assign i_jal   = (op == op_jal);

    assign r_alu     = i_addu | i_subu | i_slt | i_sltu | i_and | i_or | i_xor | i_nor
                       | i_sll | i_srl | i_sra;
    assign imm_arith = i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori;
    assign defined   = r_alu | imm_arith | i_lui | i_lw | i_sw | i_beq | i_bne
                       | i_j | i_jal | i_jr;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op.add    = i_addu | i_addiu | i_lw | i_sw | i_jal; // jal computes pc + 8
        ctrl.alu_op.sub    = i_subu;
        ctrl.alu_op.slt    = i_slt | i_slti;
        ctrl.alu_op.sltu   = i_sltu | i_sltiu;
        ctrl.alu_op.op_and = i_and | i_andi;
        ctrl.alu_op.op_nor = i_nor;
        ctrl.alu_op.op_or  = i_or | i_ori;
        ctrl.alu_op.op_xor = i_xor | i_xori;
        ctrl.alu_op.sll    = i_sll;
        ctrl.alu_op.srl    = i_srl;
        ctrl.alu_op.sra    = i_sra;
        ctrl.alu_op.lui    = i_lui;
        ctrl.load_op    = i_lw;
        ctrl.mem_we     = i_sw;
        ctrl.gr_we      = r_alu | imm_arith | i_lui | i_lw | i_jal;
        ctrl.src1_is_sa = i_sll | i_srl | i_sra;
        ctrl.src1_is_pc = i_jal;
        ctrl.src2_is_8  = i_jal;
        ctrl.imm        = inst.i_view.imm;
        if (i_andi | i_ori | i_xori | i_lui)
            ctrl.src2_sel = src2_zext;
        else if (i_addiu | i_slti | i_sltiu | i_lw | i_sw)
            ctrl.src2_sel = src2_sext;
        else
            ctrl.src2_sel = src2_reg;
        if (i_jal)
            ctrl.dest = reg_ra;
        else if (imm_arith | i_lui | i_lw)
            ctrl.dest = inst.i_view.rt;
        else if (r_alu)
            ctrl.dest = inst.r_view.rd;
        else
            ctrl.dest = 5'd0; // stores, branches, jumps, undefined
    end

    always_comb begin
        br_kind = br_none;
        if (i_beq)      br_kind = br_beq;
        else if (i_bne) br_kind = br_bne;
        else if (i_j)   br_kind = br_j;
        else if (i_jal) br_kind = br_jal;
        else if (i_jr)  br_kind = br_jr;
    end

    assign rs_used = defined & ~(i_sll | i_srl | i_sra | i_lui | i_j | i_jal);
    assign rt_used = defined & ~(imm_arith | i_lw | i_lui | i_j | i_jal);

endmodule

// File: hdl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  logic                 [4:0]  rs,
    input  logic                 [4:0]  rt,
    input  logic                        rs_used,
    input  logic                        rt_used,
    input  logic                 [31:0] rf_rdata1,
    input  logic                 [31:0] rf_rdata2,
    input  decode_pkg::fwd_src_t        exe_fwd,
    input  decode_pkg::fwd_src_t        mem_fwd,
    input  decode_pkg::fwd_src_t        wb_fwd,
    input  logic                        es_load_op,
    output logic                 [31:0] rs_value,
    output logic                 [31:0] rt_value,
    output logic                        load_stall
);
    import decode_pkg::*;

    // later stage writes the register we want to read
    function automatic logic hit(input fwd_src_t f, input logic [4:0] addr);
        return f.valid && f.dest == addr && addr != 5'd0;
    endfunction

    // youngest producer wins: exe, then mem, then wb
    function automatic logic [31:0] pick(
        input logic [4:0]  addr,
        input logic        used,
        input logic [31:0] rf_val,
        input fwd_src_t    e,
        input fwd_src_t    m,
        input fwd_src_t    w
    );
        logic [31:0] val;
        val = rf_val;
        if (used) begin
            if (hit(e, addr))
                val = e.result;
            else if (hit(m, addr))
                val = m.result;
            else if (hit(w, addr))
                val = w.result;
        end
        return val;
    endfunction

    assign rs_value = pick(rs, rs_used, rf_rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign rt_value = pick(rt, rt_used, rf_rdata2, exe_fwd, mem_fwd, wb_fwd);

    // load data not ready until mem
    assign load_stall = es_load_op
                        & ((rs_used & hit(exe_fwd, rs)) | (rt_used & hit(exe_fwd, rt)));

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2,
    input  decode_pkg::rf_write_t wr
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 reads as zero, its storage is never written
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f flist.f -o sim_id_stage \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_id_stage > sim.log 2>&1 ; cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: tb/id_tests.svh
task automatic decode_case(input string name, input logic [31:0] inst, input logic [11:0] alu,
                           input src2_sel_t src2, input logic [4:0] dest, input logic gr_we,
                           input logic mem_we);
    issue(32'h0040_0000, inst);
    wait_valid(name);
    check_value({"ctrl.alu_op for ", name}, {20'd0, ds_to_es_bus.ctrl.alu_op}, {20'd0, alu});
    check_value({"ctrl.src2_sel for ", name}, {30'd0, ds_to_es_bus.ctrl.src2_sel},
                {30'd0, src2});
    check_value({"ctrl.dest for ", name}, {27'd0, ds_to_es_bus.ctrl.dest}, {27'd0, dest});
    check_bit({"ctrl.gr_we for ", name}, ds_to_es_bus.ctrl.gr_we, gr_we);
    check_bit({"ctrl.mem_we for ", name}, ds_to_es_bus.ctrl.mem_we, mem_we);
endtask

// alu_op bit order from bit 0 is add sub slt sltu and nor or xor sll srl sra lui
task automatic decode_alu_ops();
    decode_case("addu", r_inst(5'd1, 5'd2, 5'd3, 5'd0, fn_addu), 12'h001, src2_reg, 5'd3,
                1'b1, 1'b0);
    decode_case("sltu", r_inst(5'd4, 5'd5, 5'd6, 5'd0, fn_sltu), 12'h008, src2_reg, 5'd6,
                1'b1, 1'b0);
    decode_case("sra", r_inst(5'd0, 5'd7, 5'd8, 5'd3, fn_sra), 12'h400, src2_reg, 5'd8,
                1'b1, 1'b0);
    check_bit("ctrl.src1_is_sa for sra", ds_to_es_bus.ctrl.src1_is_sa, 1'b1);
    decode_case("ori", i_inst(op_ori, 5'd9, 5'd10, 16'h8001), 12'h040, src2_zext, 5'd10,
                1'b1, 1'b0);
    check_value("ctrl.imm for ori", {16'd0, ds_to_es_bus.ctrl.imm}, 32'h0000_8001);
    decode_case("lui", i_inst(op_lui, 5'd0, 5'd11, 16'h1234), 12'h800, src2_zext, 5'd11,
                1'b1, 1'b0);
    decode_case("lw", i_inst(op_lw, 5'd12, 5'd13, 16'hfffc), 12'h001, src2_sext, 5'd13,
                1'b1, 1'b0);
    check_bit("ctrl.load_op for lw", ds_to_es_bus.ctrl.load_op, 1'b1);
    decode_case("sw", i_inst(op_sw, 5'd14, 5'd15, 16'h0010), 12'h001, src2_sext, 5'd0,
                1'b0, 1'b1);
    check_bit("ctrl.load_op for sw", ds_to_es_bus.ctrl.load_op, 1'b0);
    decode_case("undefined", {6'h3f, 26'h155_5555}, 12'h000, src2_reg, 5'd0, 1'b0, 1'b0);
endtask

task automatic read_back_registers();
    logic [31:0] v [4];
    int i;
    for (i = 0; i < 4; i++) begin
        v[i] = next_rand();
        write_reg(5'(20 + i), v[i]);
    end
    write_reg(5'd0, next_rand()); // must not stick
    for (i = 0; i < 2; i++) begin
        issue(32'h0040_0100, r_inst(5'(20 + 2 * i), 5'(21 + 2 * i), 5'd1, 5'd0, fn_addu));
        wait_valid("addu reading the register file");
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, v[2 * i]);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, v[2 * i + 1]);
    end
    issue(32'h0040_0104, r_inst(5'd0, 5'd0, 5'd2, 5'd0, fn_subu));
    wait_valid("subu reading r0");
    check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, 32'd0);
    check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, 32'd0);
endtask

task automatic forward_by_priority();
    logic [31:0] v_rf;
    logic [31:0] exp_v [4];
    int k;
    v_rf = next_rand();
    for (k = 0; k < 3; k++)
        exp_v[k] = next_rand();
    exp_v[3] = v_rf; // no stage valid so the regfile value wins
    write_reg(5'd7, v_rf);
    for (k = 0; k < 4; k++) begin
        @(posedge clk);
        exe_fwd <= '{valid: k < 1, dest: 5'd7, result: exp_v[0]};
        mem_fwd <= '{valid: k < 2, dest: 5'd7, result: exp_v[1]};
        wb_fwd  <= '{valid: k < 3, dest: 5'd7, result: exp_v[2]};
        issue(32'h0040_0200, i_inst(op_ori, 5'd7, 5'd7, 16'h00ff)); // rt only a destination
        wait_valid("ori with forwarded rs");
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, exp_v[k]);
        check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, v_rf);
    end
    @(posedge clk);
    exe_fwd <= '0;
    mem_fwd <= '0;
    wb_fwd  <= '0;
endtask

task automatic stall_on_load_use();
    logic [31:0] a;
    logic [31:0] pc;
    int i;
    a  = next_rand();
    pc = 32'h0040_0300;
    write_reg(5'd9, a);
    write_reg(5'd10, a);
    @(posedge clk);
    exe_fwd    <= '{valid: 1'b1, dest: 5'd9, result: a}; // load in EXE targets r9
    es_load_op <= 1'b1;
    issue(pc, i_inst(op_beq, 5'd9, 5'd10, 16'hfff0));
    for (i = 0; i < 3; i++) begin
        @(negedge clk);
        check_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_bit("ds_allowin", ds_allowin, 1'b0);
        check_bit("br_bus.stall", br_bus.stall, 1'b1);
    end
    @(posedge clk);
    es_load_op <= 1'b0;
    @(negedge clk);
    check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_bit("ds_allowin", ds_allowin, 1'b1);
    check_bit("br_bus.stall", br_bus.stall, 1'b0);
    check_bit("br_bus.taken", br_bus.taken, 1'b1);
    check_value("br_bus.target", br_bus.target, branch_target(pc, 16'hfff0));
    @(posedge clk);
    exe_fwd <= '0;
endtask

task automatic branch_case(input string name, input logic [31:0] pc, input logic [31:0] inst,
                           input logic exp_taken, input logic [31:0] exp_target);
    issue(pc, inst);
    wait_valid(name);
    check_bit({"br_bus.is_branch for ", name}, br_bus.is_branch, 1'b1);
    check_bit({"br_bus.taken for ", name}, br_bus.taken, exp_taken);
    if (exp_taken)
        check_value({"br_bus.target for ", name}, br_bus.target, exp_target);
endtask

task automatic resolve_branches();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] r;
    logic [15:0] imm;
    logic [25:0] jidx;
    a    = next_rand();
    b    = a ^ (next_rand() | 32'd1); // never equal to a
    pc   = next_rand() & 32'hffff_fffc;
    r    = next_rand();
    imm  = r[15:0];
    jidx = r[31:6];
    write_reg(5'd11, a);
    write_reg(5'd12, a);
    write_reg(5'd13, b);
    branch_case("beq equal", pc, i_inst(op_beq, 5'd11, 5'd12, imm), 1'b1,
                branch_target(pc, imm));
    branch_case("beq unequal", pc, i_inst(op_beq, 5'd11, 5'd13, imm), 1'b0, 32'd0);
    branch_case("bne unequal", pc, i_inst(op_bne, 5'd11, 5'd13, imm), 1'b1,
                branch_target(pc, imm));
    branch_case("bne equal", pc, i_inst(op_bne, 5'd11, 5'd12, imm), 1'b0, 32'd0);
    branch_case("j", pc, j_inst(op_j, jidx), 1'b1, jump_target(pc, jidx));
    branch_case("jal", pc, j_inst(op_jal, jidx), 1'b1, jump_target(pc, jidx));
    check_value("ctrl.dest for jal", {27'd0, ds_to_es_bus.ctrl.dest}, 32'd31);
    check_bit("ctrl.gr_we for jal", ds_to_es_bus.ctrl.gr_we, 1'b1);
    check_bit("ctrl.src1_is_pc for jal", ds_to_es_bus.ctrl.src1_is_pc, 1'b1);
    check_bit("ctrl.src2_is_8 for jal", ds_to_es_bus.ctrl.src2_is_8, 1'b1);
    branch_case("jr", pc, r_inst(5'd13, 5'd0, 5'd0, 5'd0, fn_jr), 1'b1, b);
endtask

task automatic hold_under_back_pressure();
    ds_to_es_t held;
    int i;
    @(posedge clk);
    es_allowin <= 1'b0;
    issue(32'h0040_0400, r_inst(5'd20, 5'd21, 5'd4, 5'd0, fn_xor));
    wait_valid("xor under back-pressure");
    held = ds_to_es_bus;
    check_value("ds_to_es_bus.pc", held.pc, 32'h0040_0400);
    @(posedge clk);
    fs_to_ds_valid <= 1'b1; // next item waits in fetch
    fs_to_ds_bus   <= {32'h0040_0404, r_inst(5'd22, 5'd23, 5'd5, 5'd0, fn_nor)};
    for (i = 0; i < 4; i++) begin
        @(negedge clk);
        check_bit("ds_allowin", ds_allowin, 1'b0);
        check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, held.pc);
        check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, held.rs_value);
        check_value("ds_to_es_bus.ctrl.dest", {27'd0, ds_to_es_bus.ctrl.dest},
                    {27'd0, held.ctrl.dest});
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    @(posedge clk); // old item leaves and new one enters
    fs_to_ds_valid <= 1'b0;
    @(negedge clk);
    check_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, 32'h0040_0404);
endtask

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import decode_pkg::*;

    localparam int wait_limit = 50; // cycles before a wait gives up

    logic       clk;
    logic       reset;
    logic       fs_to_ds_valid;
    fetch_bus_t fs_to_ds_bus;
    logic       ds_allowin;
    logic       es_allowin;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    br_bus_t    br_bus;
    rf_write_t  ws_to_rf;
    fwd_src_t   exe_fwd;
    fwd_src_t   mem_fwd;
    fwd_src_t   wb_fwd;
    logic       es_load_op;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd93;

    id_stage DUT (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .ws_to_rf       (ws_to_rf),
        .exe_fwd        (exe_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .es_load_op     (es_load_op)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_inst(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_inst(input logic [5:0] op, input logic [25:0] jidx);
        return {op, jidx};
    endfunction

    // offset counts words from the delay slot
    function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [15:0] imm);
        return pc + 32'd4 + (32'($signed(imm)) << 2);
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] pc, input logic [25:0] jidx);
        logic [31:0] slot;
        slot = pc + 32'd4;
        return {slot[31:28], jidx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        ws_to_rf <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clk); // written at this edge
        ws_to_rf <= '0;
    endtask

    // offer one fetch item and hold it until the stage takes it
    task automatic issue(input logic [31:0] pc, input logic [31:0] inst);
        int n;
        n = 0;
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds_bus   <= {pc, inst};
        @(negedge clk);
        while (!ds_allowin && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!ds_allowin) begin
            errors++;
            $display("timeout: decode stage never accepted the item at pc %08h", pc);
        end
        @(posedge clk); // transfer edge
        fs_to_ds_valid <= 1'b0;
    endtask

    task automatic wait_valid(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_to_es_valid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!ds_to_es_valid) begin
            errors++;
            $display("timeout: %s never went out to execute", what);
        end
    endtask

    `include "id_tests.svh"

    initial begin
        reset          <= 1'b1;
        fs_to_ds_valid <= 1'b0;
        fs_to_ds_bus   <= '0;
        es_allowin     <= 1'b1;
        ws_to_rf       <= '0;
        exe_fwd        <= '0;
        mem_fwd        <= '0;
        wb_fwd         <= '0;
        es_load_op     <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_bit("br_bus.is_branch", br_bus.is_branch, 1'b0);
        check_bit("br_bus.taken", br_bus.taken, 1'b0);
        check_bit("br_bus.stall", br_bus.stall, 1'b0);
        decode_alu_ops();
        read_back_registers();
        forward_by_priority();
        stall_on_load_use();
        resolve_branches();
        hold_under_back_pressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
